// File: source/spi_reg_pkg.sv
/*
 * spi register slave shared types
 * byte and address widths, the command byte layout,
 * the shifter-to-controller byte event and the
 * register bank write port
 */
package spi_reg_pkg;

  localparam int SPI_BYTE_W = 8;              // bits per spi transfer
  localparam int SPI_ADDR_W = SPI_BYTE_W - 1; // command byte minus wr flag

  // one byte on the wire
  typedef logic [SPI_BYTE_W-1:0] spi_byte_t;

  // modules use only the low REG_AW bits of this command field
  typedef logic [SPI_ADDR_W-1:0] spi_addr_t;

  // first byte of every transaction
  typedef struct packed {
    logic      wr;   // 1 = write burst, 0 = read burst
    spi_addr_t addr; // start register
  } spi_cmd_t;

  // completed master byte from shifter to controller
  typedef struct packed {
    logic      ready; // one sclk_r cycle after the 8th rising edge
    spi_byte_t data;  // valid at the falling edge inside ready
  } byte_evt_t;

  // register bank write port
  typedef struct packed {
    logic      en;   // write strobe, sampled on falling edge
    spi_addr_t addr; // target register
    spi_byte_t data; // value to store
  } reg_wr_t;

endpackage

// File: source/spi_byte_shifter.sv
/*
 * spi byte shifter
 * bit-serial engine clocked by sclk_r, reset by ss_r low.
 * miso driven msb first on rising edges, mosi sampled on
 * falling edges. ready pulses one cycle after the 8th rising
 * edge of each byte, slave data loaded at the next one.
 */
`timescale 1ns/1ns

module spi_byte_shifter import spi_reg_pkg::*; (
  input  logic      sclk_r,
  input  logic      ss_r,
  input  logic      mosi,
  output logic      miso,
  input  spi_byte_t sdat,
  output byte_evt_t evt
);

  logic [2:0] bit_cnt_q; // bit position within the byte
  logic       ready_q;   // carry out of bit_cnt_q
  logic       mosi_l;    // mosi sampled mid-bit
  logic [6:0] dshift_q;  // slave bits going out, master bits coming in

  // mosi is stable at the falling edge
  always_ff @(negedge sclk_r) begin
    mosi_l <= mosi;
  end

  // carry of the wrapping bit counter is ready
  always_ff @(posedge sclk_r or negedge ss_r) begin
    if (!ss_r) begin
      ready_q   <= 1'b0;
      bit_cnt_q <= 3'd0;
    end else begin
      {ready_q, bit_cnt_q} <= {1'b0, bit_cnt_q} + 4'd1;
    end
  end

  // first edge of a byte loads sdat, later edges shift
  always_ff @(posedge sclk_r) begin
    if (bit_cnt_q == 3'd0) begin
      miso     <= sdat[7];
      dshift_q <= sdat[6:0];
    end else begin
      miso     <= dshift_q[6];               // next slave bit
      dshift_q <= {dshift_q[5:0], mosi_l};   // previous master bit in
    end
  end

  // after edge 8 dshift_q has seven bits and the last is still on mosi
  assign evt.ready = ready_q;
  assign evt.data  = {dshift_q, mosi}; // valid at falling edge in ready cycle

endmodule

// File: source/spi_xfer_ctrl.sv
/*
 * spi transfer controller
 * first byte of a transaction is the command, wr flag and
 * start address. each later byte is a data byte at an
 * auto-incrementing address that wraps over the bank.
 * acts on the falling edge of sclk_r while ready is high.
 */
`timescale 1ns/1ns

module spi_xfer_ctrl import spi_reg_pkg::*; #(
  parameter int REG_AW = 3 // register address width
) (
  input  logic      sclk_r,
  input  logic      ss_r,
  input  byte_evt_t evt,
  output reg_wr_t   wr,
  output spi_addr_t rd_addr,
  input  spi_byte_t rd_data,
  output spi_byte_t sdat
);

  // status register sits at the top of the bank
  localparam logic [REG_AW-1:0] STATUS_ADDR = '1;

  typedef enum logic [1:0] {
    cmd_wait, // next byte is a command
    data_rd,  // read burst in progress
    data_wr   // write burst in progress
  } ctrl_state_t;

  ctrl_state_t       state_q;
  logic [REG_AW-1:0] addr_q;  // current register
  spi_cmd_t          cmd;     // master byte seen as a command

  assign cmd = spi_cmd_t'(evt.data);

  // state and address advance only on a completed byte
  always_ff @(negedge sclk_r or negedge ss_r) begin
    if (!ss_r) begin
      state_q <= cmd_wait;
      addr_q  <= STATUS_ADDR; // status goes out during the command
    end else if (evt.ready) begin
      case (state_q)
        cmd_wait: begin
          addr_q <= cmd.addr[REG_AW-1:0]; // drop unused high bits
          if (cmd.wr) begin
            state_q <= data_wr;
          end else begin
            state_q <= data_rd;
          end
        end
        data_rd, data_wr: begin
          addr_q <= addr_q + 1'b1; // wraps modulo 2**REG_AW
        end
        default: begin
          state_q <= cmd_wait;
        end
      endcase
    end
  end

  assign rd_addr = spi_addr_t'(addr_q); // zero extended

  // write strobe lands on the same falling edge as ready
  assign wr.en   = evt.ready && (state_q == data_wr);
  assign wr.addr = rd_addr;
  assign wr.data = evt.data;

  // shifter loads this at the first edge of the next byte
  assign sdat = rd_data;

endmodule

// File: source/spi_reg_bank.sv
/*
 * spi register bank
 * 2**REG_AW byte registers written on the falling edge of
 * sclk_r. the top address is the read-only status register
 * and always reflects status_in. reads are combinational.
 */
`timescale 1ns/1ns

module spi_reg_bank import spi_reg_pkg::*; #(
  parameter int REG_AW = 3 // register address width
) (
  input  logic                       sclk_r,
  input  reg_wr_t                    wr,
  input  spi_addr_t                  rd_addr,
  output spi_byte_t                  rd_data,
  input  spi_byte_t                  status_in,
  output spi_byte_t [2**REG_AW-1:0]  ctrl_q
);

  localparam int                NREG        = 2**REG_AW;
  localparam logic [REG_AW-1:0] STATUS_ADDR = '1;

  spi_byte_t         regs_q [NREG-1]; // writable registers only
  logic [REG_AW-1:0] wr_idx;
  logic [REG_AW-1:0] rd_idx;

  assign wr_idx = wr.addr[REG_AW-1:0];
  assign rd_idx = rd_addr[REG_AW-1:0];

  // writes land on the falling edge inside ready
  always_ff @(negedge sclk_r) begin
    if (wr.en && (wr_idx != STATUS_ADDR)) begin
      regs_q[wr_idx] <= wr.data; // status writes dropped
    end
  end

  always_comb begin
    if (rd_idx == STATUS_ADDR) begin
      rd_data = status_in;
    end else begin
      rd_data = regs_q[rd_idx];
    end
  end

  // register vector with status in the top slot
  always_comb begin
    for (int i = 0; i < NREG - 1; i++) begin
      ctrl_q[i] = regs_q[i];
    end
    ctrl_q[NREG-1] = status_in;
  end

endmodule

// File: source/spi_reg_slave_top.sv
/*
 * spi register slave
 * byte shifter, transfer controller and register bank.
 * sclk_r and ss_r arrive with polarity already corrected,
 * ss_r low holds the whole slave in reset between transactions.
 */
`timescale 1ns/1ns

module spi_reg_slave_top import spi_reg_pkg::*; #(
  parameter int REG_AW = 3 // 8 registers by default
) (
  input  logic                      sclk_r,
  input  logic                      ss_r,
  input  logic                      mosi,
  input  spi_byte_t                 status_in,
  output logic                      miso,
  output spi_byte_t [2**REG_AW-1:0] ctrl_q
);

  byte_evt_t evt;     // completed master byte
  reg_wr_t   wr;      // bank write port
  spi_addr_t rd_addr; // current register
  spi_byte_t rd_data; // its contents
  spi_byte_t sdat;    // next byte out on miso

  spi_byte_shifter shifter_i (
    .sclk_r (sclk_r),
    .ss_r   (ss_r),
    .mosi   (mosi),
    .miso   (miso),
    .sdat   (sdat),
    .evt    (evt)
  );

  spi_xfer_ctrl #(
    .REG_AW (REG_AW)
  ) ctrl_i (
    .sclk_r  (sclk_r),
    .ss_r    (ss_r),
    .evt     (evt),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .sdat    (sdat)
  );

  spi_reg_bank #(
    .REG_AW (REG_AW)
  ) bank_i (
    .sclk_r    (sclk_r),
    .wr        (wr),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .status_in (status_in),
    .ctrl_q    (ctrl_q)
  );

endmodule

// File: tb/tb_clock_gen.sv
/*
 * testbench clock source
 * free-running sclk_r, starts low, fixed period
 */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 10 // full clock period
) (
  output logic clk
);

  initial begin
    clk = 1'b0; // first edge is a rising one
  end

  always begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// File: tb/tb_spi_reg_slave.sv
/*
 * spi register slave testbench
 * random spi transactions from a fixed seed against a register
 * model: write and read bursts with wraparound, status during the
 * command byte, writes across the status slot, aborted data bytes
 * and a random mix. a watchdog bounds the run.
 */
`timescale 1ns/1ns

module tb_spi_reg_slave import spi_reg_pkg::*;;

  localparam int REG_AW      = 3;
  localparam int NREG        = 2**REG_AW;
  localparam int STATUS_ADDR = NREG - 1;    // read-only top register
  localparam int BUF_LEN     = 2*NREG + 4;  // longest burst plus cmd and partial
  localparam int N_RANDOM    = 40;
  // worst case byte count of all tests
  localparam int MAX_BYTES   = NREG + (NREG + 4) + 4 + 4 + 7*3 + N_RANDOM*(2*NREG + 1);
  localparam int TIMEOUT_NS  = MAX_BYTES * 8 * 10 * 2;

  logic                  sclk_r;
  logic                  ss_r;
  logic                  mosi;
  logic                  miso;
  spi_byte_t             status_in;
  spi_byte_t [NREG-1:0]  ctrl_q;

  spi_byte_t model [NREG];     // expected register contents
  spi_byte_t tx_buf [BUF_LEN]; // master bytes, cmd first
  spi_byte_t rx_buf [BUF_LEN]; // bytes seen on miso
  integer    seed;
  int        errors;
  int        checks;
  int        test_err_start;  // error count when the current test began

  tb_clock_gen #(.PERIOD_NS(10)) clk_i (.clk(sclk_r));

  spi_reg_slave_top #(
    .REG_AW (REG_AW)
  ) dut_i (
    .sclk_r    (sclk_r),
    .ss_r      (ss_r),
    .mosi      (mosi),
    .status_in (status_in),
    .miso      (miso),
    .ctrl_q    (ctrl_q)
  );

  task automatic compare_byte(input spi_byte_t actual, input spi_byte_t expected,
                              input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  // register value a read should return
  function automatic spi_byte_t expected_reg(input int addr);
    if (addr == STATUS_ADDR) begin
      return status_in; // status slot mirrors the input
    end
    return model[addr];
  endfunction

  task automatic check_bank(input string tag);
    int i;
    for (i = 0; i < NREG; i++) begin
      compare_byte(ctrl_q[i], expected_reg(i), $sformatf("%s ctrl_q[%0d]", tag, i));
    end
  endtask

  // one ss_r window of nbytes full bytes and abort_bits of one more
  task automatic run_xfer(input int nbytes, input int abort_bits);
    int b;
    int i;
    @(posedge sclk_r);
    #1;
    status_in = $random(seed); // new status while deselected
    @(posedge sclk_r);
    #1;
    ss_r = 1'b1;
    for (b = 0; b < nbytes; b++) begin
      rx_buf[b] = '0;
      for (i = 0; i < 8; i++) begin
        @(posedge sclk_r);
        #1;
        mosi = tx_buf[b][7-i]; // msb first
        @(negedge sclk_r);
        rx_buf[b] = {rx_buf[b][6:0], miso}; // miso stable mid-bit
      end
    end
    for (i = 0; i < abort_bits; i++) begin
      @(posedge sclk_r);
      #1;
      mosi = tx_buf[nbytes][7-i];
    end
    @(posedge sclk_r);
    #1;
    ss_r = 1'b0; // ends the transaction mid-byte when aborting
    mosi = 1'b0;
  endtask

  // command plus ndata data bytes with model update and checks
  task automatic do_xfer(input logic wr_burst, input int start, input int ndata,
                         input int abort_bits, input string tag);
    spi_byte_t cmd_byte;
    int        k;
    int        addr;
    cmd_byte              = $random(seed); // unused address bits random
    cmd_byte[7]           = wr_burst;
    cmd_byte[REG_AW-1:0]  = start[REG_AW-1:0];
    tx_buf[0]             = cmd_byte;
    for (k = 1; k <= ndata + 1; k++) begin
      tx_buf[k] = $random(seed);
    end
    run_xfer(ndata + 1, abort_bits);
    compare_byte(rx_buf[0], status_in, {tag, " status during command"});
    for (k = 1; k <= ndata; k++) begin
      addr = (start + k - 1) % NREG; // wraps over the bank
      if (wr_burst) begin
        if (addr != STATUS_ADDR) begin
          model[addr] = tx_buf[k];
        end
      end else begin
        compare_byte(rx_buf[k], expected_reg(addr),
                     $sformatf("%s read byte %0d addr %0d", tag, k, addr));
      end
    end
    check_bank(tag);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - test_err_start);
    test_err_start = errors;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not complete within %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

  initial begin
    int n;
    int r;
    seed           = 32'hf8d492a1;
    errors         = 0;
    checks         = 0;
    test_err_start = 0;
    ss_r           = 1'b0; // held in reset
    mosi           = 1'b0;
    status_in      = $random(seed);
    repeat (5) @(posedge sclk_r);

    do_xfer(1'b1, 0, NREG - 1, 0, "write all");
    finish_test(1, "write burst from 0");

    do_xfer(1'b0, $random(seed) & (NREG - 1), NREG + 3, 0, "read wrap");
    finish_test(2, "read burst with wrap");

    for (n = 0; n < 4; n++) begin
      do_xfer(n[0], $random(seed) & (NREG - 1), 0, 0, "cmd only");
    end
    finish_test(3, "status during command");

    do_xfer(1'b1, NREG - 2, 3, 0, "write across status");
    finish_test(4, "write across status");

    // aborted byte lands on a writable register
    for (n = 1; n <= 7; n++) begin
      do_xfer(1'b1, {$random(seed)} % (NREG - 2), 1, n, $sformatf("abort %0d bits", n));
    end
    finish_test(5, "aborted data byte");

    for (n = 0; n < N_RANDOM; n++) begin
      r = $random(seed);
      do_xfer(r[31], r & (NREG - 1), ((r >> 8) & 'hff) % (2*NREG + 1), 0,
              $sformatf("random %0d", n));
    end
    finish_test(6, "random mix");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
source/spi_reg_pkg.sv
source/spi_byte_shifter.sv
source/spi_xfer_ctrl.sv
source/spi_reg_bank.sv
source/spi_reg_slave_top.sv
tb/tb_clock_gen.sv
tb/tb_spi_reg_slave.sv
